// ==== sim.f ====
+incdir+design
design/irq_bus_pkg.sv
design/irq_source_pkg.sv
design/irq_bus_decode.sv
design/irq_source_cell.sv
design/irq_priority_encoder.sv
design/irq_controller.sv
tests/irq_controller_checker.sv
tests/irq_controller_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module irq_controller_tb \
   -f sim.f -o irq_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/irq_sim > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see $log"
   exit 1
fi

// ==== tests/irq_controller_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "irq_settings.svh"

module irq_controller_tb
   import irq_bus_pkg::*;
   import irq_source_pkg::*;
();

   // Cycles allowed before a read response counts as lost
   localparam int WAIT_LIMIT = 8;

   logic       clock;
   logic       reset;
   bus_req_t   bus;
   logic       halt;
   logic       ack;
   irq_mask_t  request;
   bus_rsp_t   rsp;
   logic       irq;
   logic [7:0] vector;
   irq_mask_t  grant;

   int checks;
   int errors;
   int timeouts;
   int seed;

   irq_controller dut_i (
      .clock   (clock),
      .reset   (reset),
      .bus     (bus),
      .halt    (halt),
      .ack     (ack),
      .request (request),
      .rsp     (rsp),
      .irq     (irq),
      .vector  (vector),
      .grant   (grant)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   function automatic bus_req_t make_req(input logic [15:0] addr, input logic [7:0] data,
                                         input logic wr, input logic rd);
      bus_req_t r;
      r.address.full = addr;
      r.wdata        = data;
      r.write        = wr;
      r.read         = rd;
      return r;
   endfunction

   task automatic check(input string what, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One cycle of stimulus, then back to idle
   task automatic drive_cycle(input bus_req_t b, input irq_mask_t req, input logic a);
      @(posedge clock);
      bus     <= b;
      request <= req;
      ack     <= a;
      @(posedge clock);
      bus     <= make_req(16'h0000, 8'h00, 1'b0, 1'b0);
      request <= '0;
      ack     <= 1'b0;
   endtask

   task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
      drive_cycle(make_req(addr, data, 1'b1, 1'b0), '0, 1'b0);
   endtask

   // Read strobe, then poll for the response
   task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
      int cycles;
      data   = '0;
      cycles = 0;
      drive_cycle(make_req(addr, 8'h00, 1'b0, 1'b1), '0, 1'b0);
      do begin
         @(negedge clock);
         cycles++;
      end while (!rsp.rdata_valid && cycles < WAIT_LIMIT);
      if (!rsp.rdata_valid) begin
         timeouts++;
         $display("Timeout: no read response from address %h after %0d cycles", addr, cycles);
      end else begin
         data = rsp.rdata;
         // Response due right after the strobe edge, for one cycle only
         check("read latency", 8'(cycles), 8'd1);
         @(negedge clock);
         check("rdata_valid after one cycle", 8'(rsp.rdata_valid), 8'd0);
      end
   endtask

   task automatic expect_reg(input string what, input logic [15:0] addr, input logic [7:0] exp);
      logic [7:0] data;
      read_reg(addr, data);
      check(what, data, exp);
   endtask

   // Watch a short window for any response to an ignored access
   task automatic expect_no_response(input logic [15:0] addr);
      drive_cycle(make_req(addr, 8'h00, 1'b0, 1'b1), '0, 1'b0);
      repeat (3) begin
         @(negedge clock);
         check("rdata_valid for foreign address", 8'(rsp.rdata_valid), 8'd0);
      end
   endtask

   // idx below zero means nothing pending
   task automatic expect_irq(input int idx);
      irq_mask_t  exp_grant;
      logic [7:0] exp_vector;
      @(negedge clock);
      if (idx < 0) begin
         exp_grant  = '0;
         exp_vector = `IRQ_VECTOR_BASE;
      end else begin
         exp_grant  = irq_mask_t'(1) << idx;
         exp_vector = 8'(`IRQ_VECTOR_BASE + idx * `IRQ_VECTOR_STRIDE);
      end
      check("irq", 8'(irq), 8'(idx >= 0));
      check("grant", 8'(grant), 8'(exp_grant));
      check("vector", vector, exp_vector);
   endtask

   task automatic clear_regs();
      write_reg(`IRQ_IE_ADDR, 8'h00);
      write_reg(`IRQ_IF_ADDR, 8'h00);
   endtask

   task automatic test_reset_state();
      expect_irq(-1);
      check("rdata_valid after reset", 8'(rsp.rdata_valid), 8'd0);
      expect_reg("IF after reset", `IRQ_IF_ADDR, 8'h00);
      expect_reg("IE after reset", `IRQ_IE_ADDR, 8'h00);
   endtask

   task automatic test_register_access();
      logic [7:0] data;
      for (int k = 0; k < 4; k++) begin
         data = 8'($random(seed));
         write_reg(`IRQ_IF_ADDR, data);
         expect_reg("IF readback", `IRQ_IF_ADDR, data & 8'h1F);
         data = 8'($random(seed));
         write_reg(`IRQ_IE_ADDR, data);
         expect_reg("IE readback", `IRQ_IE_ADDR, data & 8'h1F);
      end
      clear_regs();
      // Wrong page with a matching offset, then wrong offsets in the I/O page
      expect_no_response(16'h0F0F);
      expect_no_response(16'hFF10);
      write_reg(16'h0FFF, 8'h1F);
      write_reg(16'hFF0E, 8'h1F);
      expect_reg("IF after foreign writes", `IRQ_IF_ADDR, 8'h00);
      expect_reg("IE after foreign writes", `IRQ_IE_ADDR, 8'h00);
   endtask

   task automatic test_request_enable();
      clear_regs();
      drive_cycle(make_req(16'h0000, 8'h00, 1'b0, 1'b0), 5'b00100, 1'b0);
      expect_irq(-1);
      expect_reg("IF after timer request", `IRQ_IF_ADDR, 8'h04);
      // Some other enable must not raise irq
      write_reg(`IRQ_IE_ADDR, 8'h01);
      expect_irq(-1);
      write_reg(`IRQ_IE_ADDR, 8'h04);
      expect_irq(2);
   endtask

   task automatic test_priority_ack();
      // Sources 1, 3 and 4 pending, served lowest index first
      int        order[3] = '{1, 3, 4};
      irq_mask_t mask;
      clear_regs();
      write_reg(`IRQ_IE_ADDR, 8'h1F);
      mask = 5'b11010;
      drive_cycle(make_req(16'h0000, 8'h00, 1'b0, 1'b0), mask, 1'b0);
      for (int k = 0; k < 3; k++) begin
         expect_irq(order[k]);
         drive_cycle(make_req(16'h0000, 8'h00, 1'b0, 1'b0), '0, 1'b1);
         // Ack drops only the granted flag
         mask = mask & ~(irq_mask_t'(1) << order[k]);
         expect_reg("IF after ack", `IRQ_IF_ADDR, 8'(mask));
      end
      expect_irq(-1);
   endtask

   task automatic test_halt();
      clear_regs();
      @(posedge clock);
      halt <= 1'b1;
      write_reg(`IRQ_IE_ADDR, 8'h1F);
      expect_reg("IE write under halt", `IRQ_IE_ADDR, 8'h00);
      drive_cycle(make_req(16'h0000, 8'h00, 1'b0, 1'b0), 5'b00001, 1'b0);
      expect_reg("IF request under halt", `IRQ_IF_ADDR, 8'h01);
      write_reg(`IRQ_IF_ADDR, 8'h06);
      expect_reg("IF write under halt", `IRQ_IF_ADDR, 8'h06);
      @(posedge clock);
      halt <= 1'b0;
      write_reg(`IRQ_IE_ADDR, 8'h02);
      expect_reg("IE write after halt", `IRQ_IE_ADDR, 8'h02);
      expect_irq(1);
   endtask

   task automatic test_request_collision();
      clear_regs();
      write_reg(`IRQ_IE_ADDR, 8'h1F);
      drive_cycle(make_req(16'h0000, 8'h00, 1'b0, 1'b0), 5'b01000, 1'b0);
      expect_irq(3);
      // Ack of source 3 together with a fresh request from it
      drive_cycle(make_req(16'h0000, 8'h00, 1'b0, 1'b0), 5'b01000, 1'b1);
      expect_irq(3);
      expect_reg("IF after ack with request", `IRQ_IF_ADDR, 8'h08);
      drive_cycle(make_req(`IRQ_IF_ADDR, 8'h00, 1'b1, 1'b0), 5'b01000, 1'b0);
      expect_reg("IF after write with request", `IRQ_IF_ADDR, 8'h08);
      write_reg(`IRQ_IF_ADDR, 8'h00);
      expect_irq(-1);
   endtask

   initial begin
      checks   = 0;
      errors   = 0;
      timeouts = 0;
      seed     = 32'h4e53_b950;
      reset    = 1'b1;
      bus      = make_req(16'h0000, 8'h00, 1'b0, 1'b0);
      halt     = 1'b0;
      ack      = 1'b0;
      request  = '0;
      repeat (16) @(posedge clock);
      reset <= 1'b0;
      test_reset_state();
      test_register_access();
      test_request_enable();
      test_priority_ack();
      test_halt();
      test_request_collision();
      $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/irq_controller_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_controller_checker
   import irq_bus_pkg::*;
   import irq_source_pkg::*;
(
   input logic      clock,
   input logic      reset,
   input bus_rsp_t  rsp,
   input logic      irq,
   input irq_mask_t grant
);

   // Read response is a single-cycle pulse
   rdata_valid_pulse: assert property (
      @(posedge clock) disable iff (reset) rsp.rdata_valid |=> !rsp.rdata_valid
   ) else $error("rdata_valid stayed high for more than one cycle");

   // At most one source granted
   grant_onehot: assert property (
      @(posedge clock) disable iff (reset) $onehot0(grant)
   ) else $error("grant has more than one bit set");

   // irq tracks a non-zero grant
   irq_matches_grant: assert property (
      @(posedge clock) disable iff (reset) irq == (grant != '0)
   ) else $error("irq does not match grant");

   // Quiet while held in reset
   quiet_in_reset: assert property (
      @(posedge clock) reset |-> (!irq && grant == '0)
   ) else $error("irq or grant active during reset");

endmodule

bind irq_controller irq_controller_checker checker_i (
   .clock (clock),
   .reset (reset),
   .rsp   (rsp),
   .irq   (irq),
   .grant (grant)
);

`default_nettype wire

// ==== design/irq_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "irq_settings.svh"

module irq_controller
   import irq_bus_pkg::*;
   import irq_source_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  bus_req_t   bus,
   input  logic       halt,
   input  logic       ack,
   input  irq_mask_t  request,
   output bus_rsp_t   rsp,
   output logic       irq,
   output logic [7:0] vector,
   output irq_mask_t  grant
);

   // Per-cell control and status
   cell_ctrl_t   [`IRQ_COUNT-1:0] ctrl;
   cell_status_t [`IRQ_COUNT-1:0] status;
   read_sel_t                     read_sel;

   // Address match, halt block, clear forming
   // grant comes back from the encoder
   irq_bus_decode decode_i (
      .bus      (bus),
      .halt     (halt),
      .ack      (ack),
      .request  (request),
      .grant    (grant),
      .ctrl     (ctrl),
      .read_sel (read_sel)
   );

   // One flag and enable pair per source
   for (genvar i = 0; i < `IRQ_COUNT; i++) begin : g_cell
      irq_source_cell cell_i (
         .clock  (clock),
         .reset  (reset),
         .ctrl   (ctrl[i]),
         .status (status[i])
      );
   end

   // Priority pick, vector and read response
   irq_priority_encoder encoder_i (
      .clock    (clock),
      .reset    (reset),
      .status   (status),
      .read_sel (read_sel),
      .irq      (irq),
      .vector   (vector),
      .grant    (grant),
      .rsp      (rsp)
   );

endmodule

`default_nettype wire

// ==== design/irq_priority_encoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "irq_settings.svh"

module irq_priority_encoder
   import irq_bus_pkg::*;
   import irq_source_pkg::*;
(
   input  logic                           clock,
   input  logic                           reset,
   input  cell_status_t [`IRQ_COUNT-1:0]  status,
   input  read_sel_t                      read_sel,
   output logic                           irq,
   output logic [7:0]                     vector,
   output irq_mask_t                      grant,
   output bus_rsp_t                       rsp
);

   irq_mask_t  flags;
   irq_mask_t  enables;
   irq_mask_t  pending;
   irq_index_t sel;
   logic       found;
   logic [`IRQ_DATA_WIDTH-1:0] rdata;
   logic       rdata_valid;

   // Gather per-cell status into masks
   always_comb begin
      for (int i = 0; i < `IRQ_COUNT; i++) begin
         flags[i]   = status[i].flag;
         enables[i] = status[i].enable;
         pending[i] = status[i].pending;
      end
   end

   // Lowest index wins
   // Scan downward so the last hit is the smallest
   always_comb begin
      found = 1'b0;
      sel   = '0;
      for (int i = `IRQ_COUNT - 1; i >= 0; i--) begin
         if (pending[i]) begin
            found = 1'b1;
            sel   = irq_index_t'(i);
         end
      end
   end

   // One-hot grant
   // Zero when nothing is pending
   assign grant = found ? irq_mask_t'(1) << sel : '0;
   assign irq   = found;

   // Idle sel is 0, so vector rests at the base
   assign vector = `IRQ_VECTOR_BASE + `IRQ_VECTOR_STRIDE * 8'(sel);

   // Read data captured on the strobe
   always_ff @(posedge clock) begin
      if (read_sel.read_if) begin
         rdata <= {{(`IRQ_DATA_WIDTH - `IRQ_COUNT){1'b0}}, flags};
      end else if (read_sel.read_ie) begin
         rdata <= {{(`IRQ_DATA_WIDTH - `IRQ_COUNT){1'b0}}, enables};
      end
   end

   // Valid for one cycle after each read
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= read_sel.read_if | read_sel.read_ie;
      end
   end

   assign rsp.rdata       = rdata;
   assign rsp.rdata_valid = rdata_valid;

endmodule

`default_nettype wire

// ==== design/irq_source_cell.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_source_cell
   import irq_source_pkg::*;
(
   input  logic         clock,
   input  logic         reset,
   input  cell_ctrl_t   ctrl,
   output cell_status_t status
);

   logic flag;
   logic enable;
   logic flag_next;

   // Flag next state
   // Write beats clear, request beats both
   always_comb begin
      flag_next = flag;
      if (ctrl.flag_write) begin
         flag_next = ctrl.flag_wdata;
      end else if (ctrl.clear) begin
         flag_next = 1'b0;
      end
      flag_next = flag_next | ctrl.request;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         flag   <= 1'b0;
         enable <= 1'b0;
      end else begin
         flag <= flag_next;
         // Halt block already applied upstream
         if (ctrl.enable_write) begin
            enable <= ctrl.enable_wdata;
         end
      end
   end

   // Status read straight from the flops
   assign status.flag    = flag;
   assign status.enable  = enable;
   assign status.pending = flag & enable;

endmodule

`default_nettype wire

// ==== design/irq_bus_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "irq_settings.svh"

module irq_bus_decode
   import irq_bus_pkg::*;
   import irq_source_pkg::*;
(
   input  bus_req_t                       bus,
   input  logic                           halt,
   input  logic                           ack,
   input  irq_mask_t                      request,
   input  irq_mask_t                      grant,
   output cell_ctrl_t [`IRQ_COUNT-1:0]    ctrl,
   output read_sel_t                      read_sel
);

   logic io_page;
   logic hit_if;
   logic hit_ie;
   logic if_write;
   logic ie_write;

   // Quick reject on the page byte
   assign io_page = (bus.address.split.page == `IRQ_IO_PAGE);

   // Exact match on the whole word
   assign hit_if = io_page && (bus.address.full == `IRQ_IF_ADDR);
   assign hit_ie = io_page && (bus.address.full == `IRQ_IE_ADDR);

   // IF writes still go through during DMA halt
   assign if_write = bus.write & hit_if;

   // IE is frozen while halted
   assign ie_write = bus.write & hit_ie & ~halt;

   // Read select goes straight to the response register
   assign read_sel.read_if = bus.read & hit_if;
   assign read_sel.read_ie = bus.read & hit_ie;

   // Fan out to each cell
   always_comb begin
      for (int i = 0; i < `IRQ_COUNT; i++) begin
         // Same strobe for all cells
         // Each cell takes its own data bit
         ctrl[i].flag_write   = if_write;
         ctrl[i].flag_wdata   = bus.wdata[i];
         ctrl[i].enable_write = ie_write;
         ctrl[i].enable_wdata = bus.wdata[i];
         // Requests pass through untouched even under halt
         ctrl[i].request      = request[i];
         // Only the granted source is cleared
         ctrl[i].clear        = ack & grant[i];
      end
   end

endmodule

`default_nettype wire

// ==== design/irq_source_pkg.sv ====
`default_nettype none

`include "irq_settings.svh"

package irq_source_pkg;

   // Source number
   // Index 0 has the highest priority
   typedef logic [2:0] irq_index_t;

   // One bit per source
   // Used for requests and for the one-hot grant
   typedef logic [`IRQ_COUNT-1:0] irq_mask_t;

   // Per-cell update controls from the bus decoder
   // request is OR-ed in after write and clear
   typedef struct packed {
      logic flag_write;
      logic flag_wdata;
      logic enable_write;
      logic enable_wdata;
      logic request;
      logic clear;
   } cell_ctrl_t;

   // Per-cell state seen by the encoder
   // pending is flag AND enable
   typedef struct packed {
      logic flag;
      logic enable;
      logic pending;
   } cell_status_t;

   // Which register a read strobe selected
   typedef struct packed {
      logic read_if;
      logic read_ie;
   } read_sel_t;

endpackage

`default_nettype wire

// ==== design/irq_bus_pkg.sv ====
`default_nettype none

package irq_bus_pkg;

   // Address split into page and offset
   // Page byte is the upper half
   typedef struct packed {
      logic [7:0] page;
      logic [7:0] offset;
   } bus_addr_split_t;

   // One address word, two readings
   // full for exact match, split for the page check
   typedef union packed {
      logic [15:0]     full;
      bus_addr_split_t split;
   } bus_addr_t;

   // Request side of the register bus
   // write and read are single-cycle strobes, never both high
   typedef struct packed {
      bus_addr_t  address;
      logic [7:0] wdata;
      logic       write;
      logic       read;
   } bus_req_t;

   // Response side of the register bus
   // Arrives one cycle after a read strobe
   typedef struct packed {
      logic [7:0] rdata;
      logic       rdata_valid;
   } bus_rsp_t;

endpackage

`default_nettype wire

// ==== design/irq_settings.svh ====
`ifndef IRQ_SETTINGS_SVH
`define IRQ_SETTINGS_SVH

// Number of interrupt sources
// Bit order follows the CPU: vblank, lcdc, timer, serial, hilo
`define IRQ_COUNT 5

// Memory-mapped register addresses
// IF sits in the I/O page, IE at the very top of the map
`define IRQ_IF_ADDR 16'hFF0F
`define IRQ_IE_ADDR 16'hFFFF

// Page byte shared by both registers
// Anything outside it is ignored by the decoder
`define IRQ_IO_PAGE 8'hFF

// Jump vector for source 0
`define IRQ_VECTOR_BASE 8'h40

// Distance between consecutive vectors
// Gives 40, 48, 50, 58, 60 for the five sources
`define IRQ_VECTOR_STRIDE 8'd8

// Width of the read data byte
// Register bits above IRQ_COUNT read as zero
`define IRQ_DATA_WIDTH 8

`endif
